/* design/hps_cmd_pkg.sv */
// Host command port definitions for the decoder and the top level
// Word, command and parameter index types plus the command codes in use
package hps_cmd_pkg;

	// One word on the host bus
	typedef logic [15:0] io_word_t;

	// First word of a frame, low byte
	typedef logic [7:0] cmd_t;

	// Parameter number within a frame
	typedef logic [7:0] param_idx_t;

	//////////////////////////////
	// Command codes
	localparam cmd_t CMD_CFG          = 8'h01;
	localparam cmd_t CMD_VIDEO_TIMING = 8'h20;
	localparam cmd_t CMD_VSET         = 8'h27;
	localparam cmd_t CMD_HSET         = 8'h37;
	localparam cmd_t CMD_AR_OVERRIDE  = 8'h3A;

	//////////////////////////////
	// Bit positions in parameter words
	localparam int CFG_CSYNC_BIT = 3;
	localparam int SYNC_POL_BIT  = 15;

endpackage

/* design/video_pkg.sv */
// Video geometry definitions for the window calculator and its divider
// Dimension and aspect types, reset frame size and calculator states
package video_pkg;

	// Pixel or line count
	typedef logic [11:0] dim_t;

	// Aspect component, bit 12 flags a direct size
	typedef logic [12:0] aspect_t;

	// Multiplier output ahead of the division
	typedef logic [23:0] product_t;

	// Window calculator FSM
	typedef enum logic [2:0] {
		WIN_IDLE,
		WIN_MUL_W,
		WIN_WAIT_W,
		WIN_MUL_H,
		WIN_WAIT_H,
		WIN_CLAMP,
		WIN_CENTER
	} win_state_t;

	// CEA 1080p frame until the host programs a timing
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

endpackage

/* design/video_ifs.sv */
`timescale 1ns/1ns
// Interfaces inside the design
// video_cfg_if carries stored configuration, muldiv_if the divider request bus

interface video_cfg_if;
	import video_pkg::*;

	// Output frame size and its limits
	dim_t    width;
	dim_t    height;
	dim_t    vset;
	dim_t    hset;
	logic    freescale;

	// Host aspect overrides
	aspect_t arc1x;
	aspect_t arc1y;
	aspect_t arc2x;
	aspect_t arc2y;

	modport decoder (output width, height, vset, hset, freescale, arc1x, arc1y, arc2x, arc2y);
	modport calc    (input  width, height, vset, hset, freescale, arc1x, arc1y, arc2x, arc2y);
endinterface

interface muldiv_if;
	import video_pkg::*;

	logic start;
	dim_t mul1;
	dim_t mul2;
	dim_t div;
	logic busy;
	dim_t result;

	modport client (output start, mul1, mul2, div, input  busy, result);
	modport unit   (input  start, mul1, mul2, div, output busy, result);
endinterface

/* design/hps_cmd_decoder.sv */
`timescale 1ns/1ns
// Host command port with clock/ack handshake
// Frames a command word and its parameters and stores the video settings

module hps_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_uio,
	input  logic                  i_io_clk,
	input  hps_cmd_pkg::io_word_t i_io_din,
	output logic                  o_io_ack,
	video_cfg_if.decoder          cfg,
	output logic                  o_csync_en,
	output logic                  o_hs_neg,
	output logic                  o_vs_neg
);
	import hps_cmd_pkg::*;
	import video_pkg::*;

	logic       rack;
	logic       strobe;
	logic       old_strobe;
	logic       has_cmd;
	cmd_t       cmd;
	param_idx_t cnt;

	//////////////////////////////
	// Handshake

	// New word while ack is still low
	assign strobe = i_io_clk & ~rack;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	//////////////////////////////
	// Framing and registers

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			old_strobe    <= 1'b0;
			has_cmd       <= 1'b0;
			cmd           <= '0;
			cnt           <= '0;
			cfg.width     <= DEF_WIDTH;
			cfg.height    <= DEF_HEIGHT;
			cfg.vset      <= '0;
			cfg.hset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arc1x     <= '0;
			cfg.arc1y     <= '0;
			cfg.arc2x     <= '0;
			cfg.arc2y     <= '0;
			o_csync_en    <= 1'b0;
			o_hs_neg      <= 1'b0;
			o_vs_neg      <= 1'b0;
		end else begin
			old_strobe <= strobe;
			if (!i_io_uio) begin
				// Frame closed so the next word is a command
				has_cmd <= 1'b0;
				cmd     <= '0;
			end else if (strobe && !old_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= i_io_din[7:0];
					cnt     <= '0;
				end else begin
					// Saturate so trailing words never alias onto word 0
					if (cnt != '1)
						cnt <= cnt + 8'd1;
					case (cmd)
						CMD_CFG: o_csync_en <= i_io_din[CFG_CSYNC_BIT];
						CMD_VIDEO_TIMING: begin
							// Porches and sync widths are not stored
							case (cnt)
								8'd0: cfg.width  <= i_io_din[11:0];
								8'd2: o_hs_neg   <= i_io_din[SYNC_POL_BIT];
								8'd4: cfg.height <= i_io_din[11:0];
								8'd6: o_vs_neg   <= i_io_din[SYNC_POL_BIT];
								default: ;
							endcase
						end
						CMD_VSET: cfg.vset <= i_io_din[11:0];
						CMD_HSET: begin
							// Free-scale flag sits in the top bit
							cfg.freescale <= i_io_din[15];
							cfg.hset      <= i_io_din[11:0];
						end
						CMD_AR_OVERRIDE: begin
							case (cnt)
								8'd0: cfg.arc1x <= i_io_din[12:0];
								8'd1: cfg.arc1y <= i_io_din[12:0];
								8'd2: cfg.arc2x <= i_io_din[12:0];
								8'd3: cfg.arc2y <= i_io_din[12:0];
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
	end

	// Host lowers its clock only while the ack is up
	a_clk_fall_on_ack: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(i_io_clk) |-> o_io_ack);

endmodule

/* design/umuldiv.sv */
`timescale 1ns/1ns
// Sequential unsigned (mul1 * mul2) / div
// Product in one cycle, then 24 restoring steps, busy while working

module umuldiv (
	input logic    clk_sys,
	input logic    resetd,
	muldiv_if.unit md
);
	import video_pkg::*;

	product_t    quo;
	product_t    quo_nx;
	dim_t        rem;
	dim_t        rem_nx;
	dim_t        divisor;
	logic [4:0]  step;
	logic [12:0] rem_sh;
	logic [12:0] rem_sub;
	logic        fits;

	// One restoring step, a zero divisor always fits and yields all ones
	assign rem_sh  = {rem, quo[23]};
	assign rem_sub = rem_sh - {1'b0, divisor};
	assign fits    = rem_sh >= {1'b0, divisor};
	assign quo_nx  = {quo[22:0], fits};
	assign rem_nx  = fits ? rem_sub[11:0] : rem_sh[11:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			md.busy <= 1'b0;
			step    <= '0;
		end else if (md.start) begin
			md.busy <= 1'b1;
			step    <= '0;
		end else if (md.busy) begin
			step <= step + 5'd1;
			if (step == 5'd23)
				md.busy <= 1'b0;
		end
	end

	// Datapath
	always_ff @(posedge clk_sys) begin
		if (md.start) begin
			quo     <= md.mul1 * md.mul2;
			rem     <= '0;
			divisor <= md.div;
		end else if (md.busy) begin
			quo <= quo_nx;
			rem <= rem_nx;
			if (step == 5'd23)
				md.result <= quo_nx[11:0];
		end
	end

	// Client must wait for the previous division
	a_no_start_busy: assert property (@(posedge clk_sys) disable iff (resetd)
		md.start |-> !md.busy);

endmodule

/* design/aspect_window_calc.sv */
`timescale 1ns/1ns
// Scaler output window from output size, limits and aspect ratio
// Loops continuously, one divider pass per axis when the ratio needs it

module aspect_window_calc (
	input  logic               clk_sys,
	input  logic               resetd,
	video_cfg_if.calc          cfg,
	// Client side driven here, unit side goes to the local divider
	muldiv_if                  md,
	input  video_pkg::aspect_t i_core_arx,
	input  video_pkg::aspect_t i_core_ary,
	output video_pkg::dim_t    o_hmin,
	output video_pkg::dim_t    o_hmax,
	output video_pkg::dim_t    o_vmin,
	output video_pkg::dim_t    o_vmax
);
	import video_pkg::*;

	win_state_t state;
	dim_t       out_w;
	dim_t       out_h;
	dim_t       arx;
	dim_t       ary;
	logic       direct;
	dim_t       wcalc;
	dim_t       hcalc;
	dim_t       videow;
	dim_t       videoh;
	dim_t       h_off;
	dim_t       v_off;

	umuldiv u_muldiv (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.md      (md)
	);

	// Centring offsets against the full frame
	assign h_off = (cfg.width - videow) >> 1;
	assign v_off = (cfg.height - videoh) >> 1;

	//////////////////////////////
	// Output size and aspect pick

	always_ff @(posedge clk_sys) begin
		out_h <= (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
		out_w <= (cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width;
		if (i_core_ary != '0) begin
			arx    <= i_core_arx[11:0];
			ary    <= i_core_ary[11:0];
			direct <= i_core_arx[12] | i_core_ary[12];
		end else if (i_core_arx == 13'd1) begin
			arx    <= cfg.arc1x[11:0];
			ary    <= cfg.arc1y[11:0];
			direct <= cfg.arc1x[12] | cfg.arc1y[12];
		end else if (i_core_arx == 13'd2) begin
			arx    <= cfg.arc2x[11:0];
			ary    <= cfg.arc2y[11:0];
			direct <= cfg.arc2x[12] | cfg.arc2y[12];
		end else begin
			arx    <= '0;
			ary    <= '0;
			direct <= 1'b0;
		end
	end

	//////////////////////////////
	// Window FSM

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= WIN_IDLE;
			md.start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md.start <= 1'b0;
			case (state)
				WIN_IDLE: begin
					if (cfg.freescale || arx == '0 || ary == '0) begin
						wcalc <= out_w;
						hcalc <= out_h;
						state <= WIN_CLAMP;
					end else if (direct) begin
						wcalc <= arx;
						hcalc <= ary;
						state <= WIN_CLAMP;
					end else begin
						state <= WIN_MUL_W;
					end
				end
				WIN_MUL_W: begin
					md.mul1  <= out_h;
					md.mul2  <= arx;
					md.div   <= ary;
					md.start <= 1'b1;
					state    <= WIN_WAIT_W;
				end
				WIN_WAIT_W: begin
					if (!md.start && !md.busy) begin
						wcalc <= md.result;
						state <= WIN_MUL_H;
					end
				end
				WIN_MUL_H: begin
					md.mul1  <= out_w;
					md.mul2  <= ary;
					md.div   <= arx;
					md.start <= 1'b1;
					state    <= WIN_WAIT_H;
				end
				WIN_WAIT_H: begin
					if (!md.start && !md.busy) begin
						hcalc <= md.result;
						state <= WIN_CLAMP;
					end
				end
				WIN_CLAMP: begin
					videow <= (wcalc > out_w) ? out_w : wcalc;
					videoh <= (hcalc > out_h) ? out_h : hcalc;
					state  <= WIN_CENTER;
				end
				WIN_CENTER: begin
					o_hmin <= h_off;
					o_hmax <= h_off + videow - 12'd1;
					o_vmin <= v_off;
					o_vmax <= v_off + videoh - 12'd1;
					state  <= WIN_IDLE;
				end
				default: state <= WIN_IDLE;
			endcase
		end
	end

endmodule

/* design/sync_polarity_fix.sv */
`timescale 1ns/1ns
// Makes one sync signal active high
// Compares high and low phase lengths and inverts when high is the longer

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	logic        s1;
	logic        s2;
	logic        pol;
	logic [23:0] cnt;
	logic [23:0] high_len;
	logic [23:0] low_len;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			pol      <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Phase length, restarts on every edge
			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 24'd1;
			if (s1 && !s2)
				low_len <= cnt;
			if (!s1 && s2)
				high_len <= cnt;
			pol <= high_len > low_len;
		end
	end

endmodule

/* design/sync_conditioner.sv */
`timescale 1ns/1ns
// Output sync path: polarity fix, composite sync and output polarity
// Outputs are registered once after the polarity-fixed inputs

module sync_conditioner (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_vid_hs,
	input  logic i_vid_vs,
	input  logic i_csync_en,
	input  logic i_hs_neg,
	input  logic i_vs_neg,
	output logic o_hs,
	output logic o_vs
);
	logic        hs_fix;
	logic        vs_fix;
	logic        prev_hs;
	logic        hs_rise;
	logic        hs_fall;
	logic        csync;
	logic [15:0] pos;
	logic [15:0] lcnt;
	logic [15:0] line_len;
	logic [15:0] hs_len;

	sync_polarity_fix u_fix_hs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vid_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix u_fix_vs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vid_vs),
		.o_sync  (vs_fix)
	);

	assign hs_rise = hs_fix & ~prev_hs;
	assign hs_fall = ~hs_fix & prev_hs;

	// Position in the line, 0 on the hsync rise
	assign pos = hs_rise ? 16'd0 : lcnt;

	// Inverted serration in vsync: high for line minus hsync width
	assign csync = vs_fix ? (pos < line_len - hs_len) : hs_fix;

	//////////////////////////////
	// Line and hsync measurement

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			lcnt     <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			prev_hs <= hs_fix;
			lcnt    <= pos + 16'd1;
			if (hs_rise)
				line_len <= lcnt;
			if (hs_fall)
				hs_len <= pos;
		end
	end

	// Final selection and polarity
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
		end else begin
			o_hs <= (i_csync_en ? csync : hs_fix) ^ i_hs_neg;
			o_vs <= (vs_fix & ~i_csync_en) ^ i_vs_neg;
		end
	end

endmodule

/* design/sys_top.sv */
`timescale 1ns/1ns
// System top: host command port, output window calculator and sync path
// All logic runs on clk_sys with the synchronous reset resetd

module sys_top (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_uio,
	input  logic                  i_io_clk,
	input  hps_cmd_pkg::io_word_t i_io_din,
	input  video_pkg::aspect_t    i_core_arx,
	input  video_pkg::aspect_t    i_core_ary,
	input  logic                  i_vid_hs,
	input  logic                  i_vid_vs,
	output logic                  o_io_ack,
	output video_pkg::dim_t       o_hmin,
	output video_pkg::dim_t       o_hmax,
	output video_pkg::dim_t       o_vmin,
	output video_pkg::dim_t       o_vmax,
	output logic                  o_hs,
	output logic                  o_vs
);
	logic csync_en;
	logic hs_neg;
	logic vs_neg;

	video_cfg_if u_vcfg ();
	muldiv_if    u_md ();

	hps_cmd_decoder u_decoder (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_clk   (i_io_clk),
		.i_io_din   (i_io_din),
		.o_io_ack   (o_io_ack),
		.cfg        (u_vcfg),
		.o_csync_en (csync_en),
		.o_hs_neg   (hs_neg),
		.o_vs_neg   (vs_neg)
	);

	aspect_window_calc u_window (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.cfg        (u_vcfg),
		.md         (u_md),
		.i_core_arx (i_core_arx),
		.i_core_ary (i_core_ary),
		.o_hmin     (o_hmin),
		.o_hmax     (o_hmax),
		.o_vmin     (o_vmin),
		.o_vmax     (o_vmax)
	);

	sync_conditioner u_sync (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_vid_hs   (i_vid_hs),
		.i_vid_vs   (i_vid_vs),
		.i_csync_en (csync_en),
		.i_hs_neg   (hs_neg),
		.i_vs_neg   (vs_neg),
		.o_hs       (o_hs),
		.o_vs       (o_vs)
	);

endmodule

/* testbench/tb_sys_top.sv */
`timescale 1ns/1ns
// Directed testbench for sys_top
// Programs the host command port, then checks the output window and the sync outputs

module tb_sys_top;
	import hps_cmd_pkg::*;
	import video_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int ACK_LIMIT   = 20;
	localparam int WIN_WAIT    = 200;
	localparam int LINE_LEN    = 40;
	localparam int HS_WIDTH    = 6;
	localparam int FRAME_LINES = 10;
	localparam int VS_LINES    = 2;
	// Window waits, host words, sync frames, then a margin
	localparam int WATCHDOG_CYCLES = 20 * WIN_WAIT + 40 * (2 * ACK_LIMIT + 2)
		+ 8 * LINE_LEN * FRAME_LINES + 1000;

	logic     clk_sys;
	logic     resetd;
	logic     i_io_uio;
	logic     i_io_clk;
	io_word_t i_io_din;
	aspect_t  i_core_arx;
	aspect_t  i_core_ary;
	logic     i_vid_hs;
	logic     i_vid_vs;
	logic     o_io_ack;
	dim_t     o_hmin;
	dim_t     o_hmax;
	dim_t     o_vmin;
	dim_t     o_vmax;
	logic     o_hs;
	logic     o_vs;

	int       check_errors;
	int       other_errors;
	int       seed;
	io_word_t params[$];

	// What the host has programmed so far
	dim_t     m_width;
	dim_t     m_height;
	dim_t     m_vset;
	dim_t     m_hset;
	logic     m_free;
	logic     m_hs_neg;
	logic     m_vs_neg;
	aspect_t  m_arc1x;
	aspect_t  m_arc1y;
	aspect_t  m_arc2x;
	aspect_t  m_arc2y;

	sys_top dut0 (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_clk   (i_io_clk),
		.i_io_din   (i_io_din),
		.i_core_arx (i_core_arx),
		.i_core_ary (i_core_ary),
		.i_vid_hs   (i_vid_hs),
		.i_vid_vs   (i_vid_vs),
		.o_io_ack   (o_io_ack),
		.o_hmin     (o_hmin),
		.o_hmax     (o_hmax),
		.o_vmin     (o_vmin),
		.o_vmax     (o_vmax),
		.o_hs       (o_hs),
		.o_vs       (o_vs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Errors: %0d check failures, %0d other failures", check_errors, other_errors);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////
	// Timing and checks

	// Ends just after a rising edge, where inputs change
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic check_dim(input dim_t got, input dim_t exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, msg, exp, got);
			check_errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, msg, exp, got);
			check_errors++;
		end
	endtask

	task automatic check_window(input dim_t hmin, input dim_t hmax, input dim_t vmin,
		input dim_t vmax, input string tag);
		check_dim(o_hmin, hmin, {tag, " hmin"});
		check_dim(o_hmax, hmax, {tag, " hmax"});
		check_dim(o_vmin, vmin, {tag, " vmin"});
		check_dim(o_vmax, vmax, {tag, " vmax"});
	endtask

	// Reference window from the programmed registers and the core ratio
	task automatic compute_window(input aspect_t carx, input aspect_t cary,
		output dim_t hmin, output dim_t hmax, output dim_t vmin, output dim_t vmax);
		dim_t out_w;
		dim_t out_h;
		dim_t ax;
		dim_t ay;
		dim_t vw;
		dim_t vh;
		logic dir;
		int   prod;
		out_h = (m_vset != '0 && m_vset < m_height) ? m_vset : m_height;
		out_w = (m_hset != '0 && m_hset < m_width) ? m_hset : m_width;
		ax = '0;
		ay = '0;
		dir = 1'b0;
		if (cary != '0) begin
			ax = carx[11:0];
			ay = cary[11:0];
			dir = carx[12] | cary[12];
		end else if (carx == 13'd1) begin
			ax = m_arc1x[11:0];
			ay = m_arc1y[11:0];
			dir = m_arc1x[12] | m_arc1y[12];
		end else if (carx == 13'd2) begin
			ax = m_arc2x[11:0];
			ay = m_arc2y[11:0];
			dir = m_arc2x[12] | m_arc2y[12];
		end
		if (m_free || ax == '0 || ay == '0) begin
			vw = out_w;
			vh = out_h;
		end else if (dir) begin
			vw = ax;
			vh = ay;
		end else begin
			// Only the low 12 bits of the quotient survive
			prod = int'(out_h) * int'(ax);
			vw = dim_t'(prod / int'(ay));
			prod = int'(out_w) * int'(ay);
			vh = dim_t'(prod / int'(ax));
		end
		if (vw > out_w)
			vw = out_w;
		if (vh > out_h)
			vh = out_h;
		hmin = (m_width - vw) >> 1;
		hmax = hmin + vw - 12'd1;
		vmin = (m_height - vh) >> 1;
		vmax = vmin + vh - 12'd1;
	endtask

	////////////////////////////////
	// Host bus

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_io_ack !== level && n < ACK_LIMIT) begin
			tick(1);
			n++;
		end
		if (o_io_ack !== level) begin
			$display("Host handshake failed at %0t: ack did not go to %b within %0d cycles",
				$time, level, ACK_LIMIT);
			other_errors++;
		end
	endtask

	task automatic host_word(input io_word_t w);
		i_io_din = w;
		i_io_clk = 1'b1;
		wait_ack(1'b1);
		i_io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	// Command word, then the queued parameter words
	task automatic host_frame(input cmd_t cmd);
		i_io_uio = 1'b1;
		host_word({8'h00, cmd});
		foreach (params[i])
			host_word(params[i]);
		params.delete();
		i_io_uio = 1'b0;
		tick(1);
	endtask

	task automatic send_timing(input dim_t w, input dim_t h, input logic hpol, input logic vpol);
		params.push_back({4'h0, w});
		params.push_back(16'd48);
		params.push_back({hpol, 15'd44});
		params.push_back(16'd88);
		params.push_back({4'h0, h});
		params.push_back(16'd4);
		params.push_back({vpol, 15'd5});
		params.push_back(16'd23);
		host_frame(CMD_VIDEO_TIMING);
		m_width = w;
		m_height = h;
		m_hs_neg = hpol;
		m_vs_neg = vpol;
	endtask

	// Active-low syncs; mode 0 settles, 1 checks levels, 2 checks csync
	task automatic run_sync(input int frames, input int mode);
		int   line;
		int   cyc;
		int   high_cnt;
		logic hs_in;
		logic vs_in;
		repeat (frames) begin
			for (line = 0; line < FRAME_LINES; line++) begin
				high_cnt = 0;
				for (cyc = 0; cyc < LINE_LEN; cyc++) begin
					hs_in = (cyc >= HS_WIDTH);
					vs_in = (line >= VS_LINES);
					i_vid_hs = hs_in;
					i_vid_vs = vs_in;
					tick(1);
					// Outputs now show the inputs of the previous cycle
					if (mode == 1) begin
						check_bit(o_hs, ~hs_in ^ m_hs_neg, "o_hs level");
						check_bit(o_vs, ~vs_in ^ m_vs_neg, "o_vs level");
					end else if (mode == 2) begin
						check_bit(o_vs, m_vs_neg, "o_vs in csync mode");
						if (o_hs ^ m_hs_neg)
							high_cnt++;
					end
				end
				if (mode == 2 && line < VS_LINES)
					check_bit(high_cnt >= LINE_LEN - HS_WIDTH - 1 &&
						high_cnt <= LINE_LEN - HS_WIDTH + 1, 1'b1,
						$sformatf("csync high %0d cycles in vsync line %0d", high_cnt, line));
			end
		end
	endtask

	////////////////////////////////
	// Directed tests

	task automatic reset_defaults();
		check_bit(o_io_ack, 1'b0, "ack after reset");
		check_dim(o_hmax, 12'd0, "hmax before first pass");
		tick(WIN_WAIT);
		check_window(12'd0, 12'd1919, 12'd0, 12'd1079, "reset defaults");
	endtask

	task automatic core_aspect_ratio();
		int   rx;
		int   ry;
		dim_t e_hmin;
		dim_t e_hmax;
		dim_t e_vmin;
		dim_t e_vmax;
		i_core_arx = 13'd4;
		i_core_ary = 13'd3;
		tick(WIN_WAIT);
		check_window(12'd240, 12'd1679, 12'd0, 12'd1079, "core 4:3");
		repeat (10) begin
			rx = ($random(seed) & 15) + 1;
			ry = ($random(seed) & 15) + 1;
			i_core_arx = aspect_t'(rx);
			i_core_ary = aspect_t'(ry);
			tick(WIN_WAIT);
			compute_window(i_core_arx, i_core_ary, e_hmin, e_hmax, e_vmin, e_vmax);
			check_window(e_hmin, e_hmax, e_vmin, e_vmax, $sformatf("core %0d:%0d", rx, ry));
		end
		i_core_arx = '0;
		i_core_ary = '0;
	endtask

	task automatic override_pairs();
		// Pair 1 is 5:4, pair 2 a direct 1000x1200 size
		params.push_back(16'd5);
		params.push_back(16'd4);
		params.push_back(16'h1000 | 16'd1000);
		params.push_back(16'h1000 | 16'd1200);
		host_frame(CMD_AR_OVERRIDE);
		m_arc1x = 13'd5;
		m_arc1y = 13'd4;
		m_arc2x = 13'h1000 | 13'd1000;
		m_arc2y = 13'h1000 | 13'd1200;
		i_core_arx = 13'd1;
		tick(WIN_WAIT);
		check_window(12'd285, 12'd1634, 12'd0, 12'd1079, "override pair 1");
		i_core_arx = 13'd2;
		tick(WIN_WAIT);
		check_window(12'd460, 12'd1459, 12'd0, 12'd1079, "override pair 2 direct");
		i_core_arx = '0;
	endtask

	task automatic timing_and_limits();
		send_timing(12'd800, 12'd600, 1'b0, 1'b0);
		params.push_back(16'd480);
		host_frame(CMD_VSET);
		m_vset = 12'd480;
		tick(WIN_WAIT);
		check_window(12'd0, 12'd799, 12'd60, 12'd539, "height limit");
		params.push_back(16'h8000 | 16'd640);
		host_frame(CMD_HSET);
		m_free = 1'b1;
		m_hset = 12'd640;
		tick(WIN_WAIT);
		check_window(12'd80, 12'd719, 12'd60, 12'd539, "free scale");
	endtask

	task automatic sync_conditioning();
		run_sync(2, 0);
		run_sync(1, 1);
		send_timing(12'd800, 12'd600, 1'b1, 1'b1);
		run_sync(1, 0);
		run_sync(1, 1);
		params.push_back(16'h0008);
		host_frame(CMD_CFG);
		run_sync(1, 0);
		run_sync(1, 2);
		params.push_back(16'h0000);
		host_frame(CMD_CFG);
	endtask

	task automatic command_framing();
		params.push_back(16'h0000);
		params.push_back(16'h0123);
		host_frame(8'h55);
		tick(WIN_WAIT);
		check_window(12'd80, 12'd719, 12'd60, 12'd539, "unknown command");
		// Word after the frame closed becomes command 0x40
		host_frame(CMD_VIDEO_TIMING);
		i_io_uio = 1'b1;
		host_word(16'h0140);
		i_io_uio = 1'b0;
		tick(WIN_WAIT);
		check_window(12'd80, 12'd719, 12'd60, 12'd539, "word after frame end");
	endtask

	initial begin
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_core_arx = '0;
		i_core_ary = '0;
		i_vid_hs = 1'b1;
		i_vid_vs = 1'b1;
		check_errors = 0;
		other_errors = 0;
		seed = 81898;
		m_width = DEF_WIDTH;
		m_height = DEF_HEIGHT;
		m_vset = '0;
		m_hset = '0;
		m_free = 1'b0;
		m_hs_neg = 1'b0;
		m_vs_neg = 1'b0;
		m_arc1x = '0;
		m_arc1y = '0;
		m_arc2x = '0;
		m_arc2y = '0;
		tick(4);
		resetd = 1'b0;
		reset_defaults();
		core_aspect_ratio();
		override_pairs();
		timing_and_limits();
		sync_conditioning();
		command_framing();
		$display("Errors: %0d check failures, %0d other failures", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* project.f */
design/hps_cmd_pkg.sv
design/video_pkg.sv
design/video_ifs.sv
design/hps_cmd_decoder.sv
design/umuldiv.sv
design/aspect_window_calc.sv
design/sync_polarity_fix.sv
design/sync_conditioner.sv
design/sys_top.sv
testbench/tb_sys_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sys_top simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sys_top \
	-f project.f -o tb_sys_top
./obj_dir/tb_sys_top > sim.log
cat sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi
